//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = egress_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SOURCES  = egress_settings.svh egress_ctrl_pkg.sv egress_data_pkg.sv egress_port_fifo.sv \
           egress_sched.sv egress_tx_lanes.sv egress_top.sv egress_tb.sv

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- egress_ctrl_pkg.sv
/*
  Egress control types
  - Port number and per-port mask
  - Scheduler FSM states
*/

`include "egress_settings.svh"

package egress_ctrl_pkg;

  // ==============================
  // Port addressing
  // ==============================

  // Destination port number
  typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] port_id_t;

  // One bit per port: full, pending, pause, grant
  typedef logic [`EGR_NUM_PORTS-1:0] port_mask_t;

  // ==============================
  // Scheduler FSM
  // ==============================
  typedef enum logic {
    SCHED_IDLE,
    SCHED_SEND
  } sched_state_t;

endpackage

//--- egress_data_pkg.sv
/*
  Egress data path types
  - Packet data word
  - FIFO pointer and occupancy widths
  - Tagged packet word carried from input to lanes
*/

`include "egress_settings.svh"

package egress_data_pkg;

  // Raw payload of one word
  typedef logic [`EGR_DATA_W-1:0] egr_data_t;

  // FIFO slot index
  typedef logic [$clog2(`EGR_FIFO_DEPTH)-1:0] fifo_ptr_t;

  // Occupancy, one extra bit to hold the full count
  typedef logic [$clog2(`EGR_FIFO_DEPTH):0] fifo_cnt_t;

  // ==============================
  // Packet word as seen on every bus
  // ==============================
  typedef struct packed {
    egr_data_t                 data;
    logic                      sop;
    logic                      eop;
    egress_ctrl_pkg::port_id_t port;
  } egr_word_t;

endpackage

//--- egress_port_fifo.sv
/*
  Per-port word FIFO
  - Circular buffer with word count
  - Complete packet counter driving pending
  - Checks on write when full and read when empty
*/

`timescale 1ns/1ns

`include "egress_settings.svh"

module egress_port_fifo (
  input  logic                       egress_clock,
  input  logic                       arst_n,
  input  logic                       wr_en,
  input  egress_data_pkg::egr_word_t wr_word,
  input  logic                       rd_en,
  output egress_data_pkg::egr_word_t head_word,
  output logic                       full,
  output logic                       pending
);

  // Word storage
  egress_data_pkg::egr_word_t mem [0:`EGR_FIFO_DEPTH-1];

  egress_data_pkg::fifo_ptr_t wr_ptr;
  egress_data_pkg::fifo_ptr_t rd_ptr;
  egress_data_pkg::fifo_cnt_t count;
  // Packets whose eop word is held
  egress_data_pkg::fifo_cnt_t pkt_cnt;

  logic pkt_in;
  logic pkt_out;

  // ==============================
  // Storage write
  // ==============================
  always_ff @(posedge egress_clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Head is always the oldest slot
  assign head_word = mem[rd_ptr];

  assign pkt_in  = wr_en && wr_word.eop;
  assign pkt_out = rd_en && head_word.eop;

  // ==============================
  // Pointers and counters
  // ==============================
  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      pkt_cnt <= '0;
    end else begin
      // Pointers wrap at the power-of-two depth
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
      // Same-cycle eop in and out cancel
      if (pkt_in && !pkt_out) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end else if (pkt_out && !pkt_in) begin
        pkt_cnt <= pkt_cnt - 1'b1;
      end
    end
  end

  assign full    = (count == egress_data_pkg::fifo_cnt_t'(`EGR_FIFO_DEPTH));
  assign pending = (pkt_cnt != '0);

  // Source must watch full before strobing
  a_no_wr_full: assert property (@(posedge egress_clock) disable iff (!arst_n)
    wr_en |-> !full);

  // Scheduler only reads a port holding a packet
  a_no_rd_empty: assert property (@(posedge egress_clock) disable iff (!arst_n)
    rd_en |-> (count != '0));

endmodule

//--- egress_sched.sv
/*
  Packet-level round-robin scheduler
  - IDLE picks a pending, unpaused port after the last grant
  - SEND reads the granted FIFO up to eop, stalled by pause
  - Read word registered onto sched_word
*/

`timescale 1ns/1ns

`include "egress_settings.svh"

module egress_sched (
  input  logic                        egress_clock,
  input  logic                        arst_n,
  input  egress_ctrl_pkg::port_mask_t pending,
  input  egress_ctrl_pkg::port_mask_t pause,
  input  egress_data_pkg::egr_word_t  head_words [0:`EGR_NUM_PORTS-1],
  output egress_ctrl_pkg::port_mask_t rd_en,
  output logic                        sched_valid,
  output egress_data_pkg::egr_word_t  sched_word
);

  egress_ctrl_pkg::sched_state_t state;
  egress_ctrl_pkg::port_id_t     grant_id;
  // First port searched in IDLE
  egress_ctrl_pkg::port_id_t     rr_ptr;

  egress_ctrl_pkg::port_mask_t   eligible;
  egress_ctrl_pkg::port_id_t     cand;
  egress_ctrl_pkg::port_id_t     pick_id;
  logic                          pick_valid;
  logic                          rd_fire;

  // ==============================
  // Round-robin pick
  // ==============================
  assign eligible = pending & ~pause;

  always_comb begin
    pick_valid = 1'b0;
    pick_id    = '0;
    cand       = '0;
    for (int i = 0; i < `EGR_NUM_PORTS; i++) begin
      // Index wraps with the port id width
      cand = egress_ctrl_pkg::port_id_t'(rr_ptr + i);
      if (!pick_valid && eligible[cand]) begin
        pick_valid = 1'b1;
        pick_id    = cand;
      end
    end
  end

  // Read in SEND unless the granted lane is paused
  assign rd_fire = (state == egress_ctrl_pkg::SCHED_SEND) && !pause[grant_id];
  assign rd_en   = rd_fire ? (egress_ctrl_pkg::port_mask_t'(1) << grant_id) : '0;

  // ==============================
  // FSM
  // ==============================
  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      state       <= egress_ctrl_pkg::SCHED_IDLE;
      grant_id    <= '0;
      rr_ptr      <= '0;
      sched_valid <= 1'b0;
    end else begin
      sched_valid <= rd_fire;
      case (state)
        egress_ctrl_pkg::SCHED_IDLE: begin
          if (pick_valid) begin
            state    <= egress_ctrl_pkg::SCHED_SEND;
            grant_id <= pick_id;
            rr_ptr   <= pick_id + 1'b1;
          end
        end
        default: begin
          // Whole packet sent once eop leaves
          if (rd_fire && head_words[grant_id].eop) begin
            state <= egress_ctrl_pkg::SCHED_IDLE;
          end
        end
      endcase
    end
  end

  // Output word register
  always_ff @(posedge egress_clock) begin
    if (rd_fire) sched_word <= head_words[grant_id];
  end

  // Granted FIFO keeps its packet counted until eop is read
  a_rd_pending: assert property (@(posedge egress_clock) disable iff (!arst_n)
    rd_fire |-> pending[grant_id]);

endmodule

//--- egress_settings.svh
/*
  Egress stage build settings
  - Port and lane count
  - Packet data word width
  - Per-port FIFO depth in words
*/

`ifndef EGRESS_SETTINGS_SVH
`define EGRESS_SETTINGS_SVH

// ==============================
// Egress dimensions
// ==============================

// Ports and transmit lanes, power of two
`define EGR_NUM_PORTS 4

// Payload bits per packet word
`define EGR_DATA_W 32

// Words per port FIFO, power of two
`define EGR_FIFO_DEPTH 16

`endif

//--- egress_tb.sv
/*
  Egress stage testbench
  - Clock, reset and LCG stimulus
  - Per-port expected queues and round-robin model
  - Lane order, pause and full checks
  - Watchdog bounding the run
*/

`timescale 1ns/1ns

`include "egress_settings.svh"

module egress_tb;

  // ==============================
  // Run length
  // ==============================
  localparam int NUM_PKTS   = 60;
  localparam int MAX_LEN    = 6;
  // Random packets, three round-robin rounds, worst-case fill packets
  localparam int TOTAL_PKTS = NUM_PKTS + 3 * `EGR_NUM_PORTS + `EGR_FIFO_DEPTH;
  localparam int WD_CYCLES  = TOTAL_PKTS * MAX_LEN * 40 + 1000;

  logic                        egress_clock = 1'b0;
  logic                        arst_n;
  logic                        in_valid;
  egress_data_pkg::egr_word_t  in_word;
  egress_ctrl_pkg::port_mask_t full;
  egress_ctrl_pkg::port_mask_t pause;
  egress_ctrl_pkg::port_mask_t tx_valid;
  egress_data_pkg::egr_word_t  tx_word [0:`EGR_NUM_PORTS-1];

  // Model state
  logic [31:0]                 rnd_state = 32'hf39;
  egress_data_pkg::egr_word_t  exp_q [`EGR_NUM_PORTS][$];
  egress_ctrl_pkg::port_id_t   sop_seen [$];
  egress_ctrl_pkg::port_id_t   exp_rr = '0;
  logic [`EGR_NUM_PORTS-1:0]   in_pkt = '0;
  int                          pause_age [`EGR_NUM_PORTS];
  int                          err_data;
  int                          err_order;
  int                          err_pause;
  int                          err_misc;

  egress_top dut0 (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_word      (in_word),
    .full         (full),
    .pause        (pause),
    .tx_valid     (tx_valid),
    .tx_word      (tx_word)
  );

  always #10 egress_clock = ~egress_clock;

  function automatic logic [31:0] lcg_next();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  function automatic int queued_words();
    int n;
    n = 0;
    for (int p = 0; p < `EGR_NUM_PORTS; p++) n += exp_q[p].size();
    return n;
  endfunction

  // ==============================
  // Bus driving
  // ==============================
  // Called right after a rising edge
  task automatic put_word(input egress_ctrl_pkg::port_id_t p, input logic sop, input logic eop);
    egress_data_pkg::egr_word_t w;
    w.data = egress_data_pkg::egr_data_t'(lcg_next());
    w.sop  = sop;
    w.eop  = eop;
    w.port = p;
    in_valid <= 1'b1;
    in_word  <= w;
    exp_q[p].push_back(w);
  endtask

  // Back to back words, caller knows the FIFO has room
  task automatic send_packet(input egress_ctrl_pkg::port_id_t p, input int len);
    for (int i = 0; i < len; i++) begin
      @(posedge egress_clock);
      put_word(p, i == 0, i == len - 1);
    end
    @(posedge egress_clock);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (queued_words() != 0 && n < max_cycles) begin
      @(negedge egress_clock);
      n++;
    end
    if (queued_words() != 0) begin
      err_misc++;
      $display("Lanes stopped sending with %0d expected words left", queued_words());
    end
    repeat (4) @(negedge egress_clock);
  endtask

  // One packet per port under full pause, then a joint release
  task automatic rr_round();
    @(posedge egress_clock);
    pause <= '1;
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      send_packet(egress_ctrl_pkg::port_id_t'(p), 1 + int'(lcg_next() % MAX_LEN));
    end
    repeat (3) @(posedge egress_clock);
    sop_seen.delete();
    pause <= '0;
    wait_drain(200);
    if (sop_seen.size() != `EGR_NUM_PORTS) begin
      err_order++;
      $display("Error at %0t ns: %0d packets started, expected %0d", $time,
               sop_seen.size(), `EGR_NUM_PORTS);
    end
    // All ports pending, so grants walk from the pointer
    for (int k = 0; k < sop_seen.size(); k++) begin
      if (sop_seen[k] != exp_rr) begin
        err_order++;
        $display("Error at %0t ns: grant %0d went to port %0d, expected %0d", $time, k,
                 sop_seen[k], exp_rr);
      end
      exp_rr = exp_rr + 1'b1;
    end
  endtask

  // Paused port filled to depth, then released
  task automatic fill_port(input egress_ctrl_pkg::port_id_t p);
    int left;
    int len;
    int n;
    @(posedge egress_clock);
    pause <= egress_ctrl_pkg::port_mask_t'(1) << p;
    left = `EGR_FIFO_DEPTH;
    while (left > 0) begin
      len = 1 + int'(lcg_next() % MAX_LEN);
      if (len > left) len = left;
      send_packet(p, len);
      left -= len;
    end
    @(negedge egress_clock);
    if (full[p] !== 1'b1) begin
      err_misc++;
      $display("Error at %0t ns: full[%0d] is %b with %0d words held", $time, p, full[p],
               `EGR_FIFO_DEPTH);
    end
    @(posedge egress_clock);
    pause <= '0;
    n = 0;
    while (full[p] && n < 10) begin
      @(negedge egress_clock);
      n++;
    end
    if (full[p] !== 1'b0) begin
      err_misc++;
      $display("Error at %0t ns: full[%0d] still high after release", $time, p);
    end
    wait_drain(400);
    // Only this port was granted, pointer now just past it
    exp_rr = p + 1'b1;
  endtask

  // Interleaved ports, each packet contiguous on its own port
  task automatic random_traffic();
    int                          rem [`EGR_NUM_PORTS];
    int                          pkt_len [`EGR_NUM_PORTS];
    int                          started;
    int                          cyc;
    int                          busy;
    logic [31:0]                 r;
    egress_ctrl_pkg::port_id_t   p;
    egress_ctrl_pkg::port_mask_t full_s;
    logic                        bus_hit;
    started = 0;
    cyc     = 0;
    foreach (rem[i]) rem[i] = 0;
    do begin
      @(negedge egress_clock);
      full_s  = full;
      r       = lcg_next();
      p       = egress_ctrl_pkg::port_id_t'(r[9:8]);
      // Word on the bus is not yet counted in full
      bus_hit = in_valid && (in_word.port == p);
      @(posedge egress_clock);
      if (cyc % 16 == 0) pause <= egress_ctrl_pkg::port_mask_t'(r[3:0] & r[7:4]);
      if (r[12:10] != 3'd0 && !full_s[p] && !bus_hit && (rem[p] > 0 || started < NUM_PKTS)) begin
        if (rem[p] == 0) begin
          rem[p]     = 1 + int'(lcg_next() % MAX_LEN);
          pkt_len[p] = rem[p];
          started++;
        end
        put_word(p, rem[p] == pkt_len[p], rem[p] == 1);
        rem[p]--;
      end else begin
        in_valid <= 1'b0;
      end
      cyc++;
      busy = 0;
      foreach (rem[i]) busy += rem[i];
    end while (started < NUM_PKTS || busy != 0);
    @(posedge egress_clock);
    in_valid <= 1'b0;
    pause    <= '0;
    wait_drain(NUM_PKTS * MAX_LEN * 8);
  endtask

  // ==============================
  // Lane monitor
  // ==============================
  always @(negedge egress_clock) begin : lane_monitor
    egress_data_pkg::egr_word_t want;
    if (arst_n) begin
      for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
        pause_age[p] = pause[p] ? pause_age[p] + 1 : 0;
        if (tx_valid[p]) begin
          // Two register stages may still drain after pause
          if (pause_age[p] >= 3) begin
            err_pause++;
            $display("Error at %0t ns: lane %0d valid after %0d paused cycles", $time, p,
                     pause_age[p]);
          end
          if (exp_q[p].size() == 0) begin
            err_data++;
            $display("Error at %0t ns: lane %0d sent %h with none expected", $time, p,
                     tx_word[p]);
          end else begin
            want = exp_q[p].pop_front();
            if (tx_word[p] !== want) begin
              err_data++;
              $display("Error at %0t ns: lane %0d got %h, expected %h", $time, p,
                       tx_word[p], want);
            end
          end
          // sop only when no packet is open on the lane
          if (tx_word[p].sop == in_pkt[p]) begin
            err_order++;
            $display("Error at %0t ns: lane %0d sop %b inside open packet %b", $time, p,
                     tx_word[p].sop, in_pkt[p]);
          end
          if (tx_word[p].sop) sop_seen.push_back(egress_ctrl_pkg::port_id_t'(p));
          in_pkt[p] = !tx_word[p].eop;
        end
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_word  = '0;
    pause    = '0;
    repeat (3) @(posedge egress_clock);
    arst_n <= 1'b1;
    @(negedge egress_clock);
    if (tx_valid !== '0 || full !== '0) begin
      err_misc++;
      $display("Error at %0t ns: tx_valid %b full %b after reset", $time, tx_valid, full);
    end
    rr_round();
    // Pointer wrapped, same order again
    rr_round();
    fill_port(egress_ctrl_pkg::port_id_t'(2));
    // Search now starts after port 2
    rr_round();
    random_traffic();
    $display("Check summary: data %0d, order %0d, pause %0d, other %0d errors", err_data,
             err_order, err_pause, err_misc);
    if (err_data + err_order + err_pause + err_misc == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * 20);
    $display("Run timed out before all packets left the lanes");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- egress_top.sv
/*
  Egress stage top level
  - Write decode of the input bus to four port FIFOs
  - Round-robin scheduler and transmit lane stage
*/

`timescale 1ns/1ns

`include "egress_settings.svh"

module egress_top (
  input  logic                        egress_clock,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  egress_data_pkg::egr_word_t  in_word,
  output egress_ctrl_pkg::port_mask_t full,
  input  egress_ctrl_pkg::port_mask_t pause,
  output egress_ctrl_pkg::port_mask_t tx_valid,
  output egress_data_pkg::egr_word_t  tx_word [0:`EGR_NUM_PORTS-1]
);

  egress_ctrl_pkg::port_mask_t wr_en;
  egress_ctrl_pkg::port_mask_t rd_en;
  egress_ctrl_pkg::port_mask_t pending;
  egress_data_pkg::egr_word_t  head_words [0:`EGR_NUM_PORTS-1];

  logic                        sched_valid;
  egress_data_pkg::egr_word_t  sched_word;

  // ==============================
  // Input side FIFOs
  // ==============================
  for (genvar g = 0; g < `EGR_NUM_PORTS; g++) begin : g_port
    // Write strobe for this port
    assign wr_en[g] = in_valid && (in_word.port == egress_ctrl_pkg::port_id_t'(g));

    egress_port_fifo u_fifo (
      .egress_clock (egress_clock),
      .arst_n       (arst_n),
      .wr_en        (wr_en[g]),
      .wr_word      (in_word),
      .rd_en        (rd_en[g]),
      .head_word    (head_words[g]),
      .full         (full[g]),
      .pending      (pending[g])
    );
  end

  // Scheduler
  egress_sched u_sched (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .pending      (pending),
    .pause        (pause),
    .head_words   (head_words),
    .rd_en        (rd_en),
    .sched_valid  (sched_valid),
    .sched_word   (sched_word)
  );

  // Output lanes
  egress_tx_lanes u_lanes (
    .egress_clock (egress_clock),
    .arst_n       (arst_n),
    .sched_valid  (sched_valid),
    .sched_word   (sched_word),
    .tx_valid     (tx_valid),
    .tx_word      (tx_word)
  );

endmodule

//--- egress_tx_lanes.sv
/*
  Transmit lane stage
  - Steers each scheduled word onto the lane of its port
  - One-cycle tx_valid per word, idle lanes hold last word
*/

`timescale 1ns/1ns

`include "egress_settings.svh"

module egress_tx_lanes (
  input  logic                        egress_clock,
  input  logic                        arst_n,
  input  logic                        sched_valid,
  input  egress_data_pkg::egr_word_t  sched_word,
  output egress_ctrl_pkg::port_mask_t tx_valid,
  output egress_data_pkg::egr_word_t  tx_word [0:`EGR_NUM_PORTS-1]
);

  // Lane select decoded from the word tag
  egress_ctrl_pkg::port_mask_t lane_sel;

  assign lane_sel = sched_valid ? (egress_ctrl_pkg::port_mask_t'(1) << sched_word.port) : '0;

  // ==============================
  // Lane valid
  // ==============================
  always_ff @(posedge egress_clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_valid <= '0;
    end else begin
      tx_valid <= lane_sel;
    end
  end

  // ==============================
  // Lane data
  // ==============================
  always_ff @(posedge egress_clock) begin
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      // Only the selected lane loads
      if (lane_sel[p]) begin
        tx_word[p] <= sched_word;
      end
    end
  end

endmodule

//--- vlog.f
+incdir+.
egress_ctrl_pkg.sv
egress_data_pkg.sv
egress_port_fifo.sv
egress_sched.sv
egress_tx_lanes.sv
egress_top.sv
egress_tb.sv
